// File: verilog.f
rtl/mem_noc_pkg.sv
rtl/tile_cfg_regs.sv
rtl/mem_addr_map.sv
rtl/mem_cmd_packetizer.sv
rtl/mem_noc_tile_out.sv
testbench/tb_mem_noc_tile_out.sv

// File: Makefile
TOP = tb_mem_noc_tile_out

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# The run fails unless the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

// File: testbench/tb_mem_noc_tile_out.sv
`timescale 1ns/10ps

module tb_mem_noc_tile_out
  import mem_noc_pkg::*;
;

  localparam int num_core_lp      = 4;
  localparam int mem_noc_x_dim_lp = 2;
  localparam int clk_period_lp    = 20;
  // The tests need about 160 cycles, the limit leaves ten times that
  localparam int max_cycles_lp    = 2000;

  typedef struct packed {
    int                               due;
    logic [mem_noc_cord_width_gp-1:0] dst_cord;
    logic [mem_noc_cid_width_gp-1:0]  dst_cid;
    logic [mem_noc_cord_width_gp-1:0] src_cord;
    logic                             opcode;
    logic [paddr_width_gp-1:0]        addr;
    logic [dword_width_gp-1:0]        data;
  } pkt_exp_t;

  logic                             clk_i;
  logic                             rst_n_i;
  logic                             cfg_w_v_i;
  logic                             cfg_addr_i;
  logic [mem_noc_cord_width_gp-1:0] cfg_data_i;
  logic [mem_noc_cord_width_gp-1:0] cfg_data_o;
  logic                             cmd_v_i;
  logic                             cmd_opcode_i;
  logic [paddr_width_gp-1:0]        cmd_addr_i;
  logic [dword_width_gp-1:0]        cmd_data_i;
  logic                             pkt_v_o;
  logic [mem_noc_cord_width_gp-1:0] pkt_dst_cord_o;
  logic [mem_noc_cid_width_gp-1:0]  pkt_dst_cid_o;
  logic [mem_noc_cord_width_gp-1:0] pkt_src_cord_o;
  logic                             pkt_opcode_o;
  logic [paddr_width_gp-1:0]        pkt_addr_o;
  logic [dword_width_gp-1:0]        pkt_data_o;

  integer                           seed;
  int                               tick;
  int                               cycles;
  int                               error_count;
  int                               check_count;
  int                               test_count;
  int                               test_start_errors;
  // Configuration the DUT should hold, kept in step with every write
  logic [mem_noc_cord_width_gp-1:0] model_cord;
  logic                             model_dram_en;
  pkt_exp_t                         exp_q[$];

  mem_noc_tile_out #(
    .num_core_p      (num_core_lp),
    .mem_noc_x_dim_p (mem_noc_x_dim_lp)
  ) dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(clk_period_lp / 2) clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles >= max_cycles_lp)
    begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles_lp);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Cores fill a grid from column 2 and row 1, x_dim cores per row
  function automatic logic [mem_noc_cord_width_gp-1:0] core_cord(input int core_id);
    logic [mem_noc_x_cord_width_gp-1:0] x;
    logic [mem_noc_y_cord_width_gp-1:0] y;
    x = mem_noc_x_cord_width_gp'(core_id % mem_noc_x_dim_lp + 2);
    y = mem_noc_y_cord_width_gp'(core_id / mem_noc_x_dim_lp + 1);
    return {y, x};
  endfunction

  // Expected destination, returned as {coordinate, client id}
  function automatic logic [mem_noc_cord_width_gp+mem_noc_cid_width_gp-1:0] route_model
    (input logic [paddr_width_gp-1:0]        addr,
     input logic [mem_noc_cord_width_gp-1:0] cord,
     input logic                             dram_en);
    logic [3:0]                       x;
    logic [3:0]                       y;
    logic [mem_noc_cord_width_gp-1:0] dram_dst;
    x = cord[3:0];
    y = cord[7:4];
    dram_dst = dram_en ? {y + 4'd1, x} : 8'h00;
    if (addr[39:38] != 2'b00)
      return {8'h00, cid_base_gp};
    if (addr >= 40'h00_8000_0000)
      return {dram_dst, cid_base_gp};
    case (addr[23:20])
      dev_host_gp:   return {8'h00, cid_base_gp};
      dev_cfg_gp:    return {core_cord(int'(addr[17:16])), cid_cfg_gp};
      dev_cce_gp:    return {cord, cid_base_gp};
      dev_plic_gp:   return {core_cord(int'(addr[4:3])), cid_base_gp};
      dev_coproc_gp: return {y, x + 4'd1, cid_base_gp};
      dev_clint_gp:
      begin
        if (addr[15:12] == clint_ipi_gp)
          return {core_cord(int'(addr[3:2])), cid_clint_gp};
        else if (addr[15:12] == clint_mtimecmp_gp)
          return {core_cord(int'(addr[4:3])), cid_clint_gp};
        else if (addr[15:12] == clint_mtime_gp)
          return {cord, cid_clint_gp};
        else
          return {dram_dst, cid_base_gp};
      end
      default:       return {dram_dst, cid_base_gp};
    endcase
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input logic [dword_width_gp-1:0] got,
                            input logic [dword_width_gp-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_route(input logic [mem_noc_cord_width_gp-1:0] got_cord,
                             input logic [mem_noc_cid_width_gp-1:0]  got_cid,
                             input logic [mem_noc_cord_width_gp-1:0] exp_cord,
                             input logic [mem_noc_cid_width_gp-1:0]  exp_cid);
    check_count++;
    if (got_cord !== exp_cord || got_cid !== exp_cid)
    begin
      error_count++;
      $display("error at %0t ns: route is cord %h cid %0d, expected cord %h cid %0d",
               $time, got_cord, got_cid, exp_cord, exp_cid);
    end
  endtask

  // Advance one cycle and compare the packet outputs 1 ns after the edge
  task automatic next_cycle();
    pkt_exp_t want;
    @(posedge clk_i);
    #1;
    tick++;
    cmd_v_i   = 1'b0;
    cfg_w_v_i = 1'b0;
    if (exp_q.size() != 0 && exp_q[0].due == tick)
    begin
      want = exp_q.pop_front();
      check_bit("pkt_v_o", pkt_v_o, 1'b1);
      check_route(pkt_dst_cord_o, pkt_dst_cid_o, want.dst_cord, want.dst_cid);
      check_word("pkt_src_cord_o", dword_width_gp'(pkt_src_cord_o),
                 dword_width_gp'(want.src_cord));
      check_bit("pkt_opcode_o", pkt_opcode_o, want.opcode);
      check_word("pkt_addr_o", dword_width_gp'(pkt_addr_o), dword_width_gp'(want.addr));
      check_word("pkt_data_o", pkt_data_o, want.data);
    end
    else
    begin
      check_bit("pkt_v_o", pkt_v_o, 1'b0);
    end
  endtask

  task automatic send_cmd(input logic opcode, input logic [paddr_width_gp-1:0] addr,
                          input logic [dword_width_gp-1:0] data);
    pkt_exp_t                                              want;
    logic [mem_noc_cord_width_gp+mem_noc_cid_width_gp-1:0] route;
    route         = route_model(addr, model_cord, model_dram_en);
    want.due      = tick + 2;
    want.dst_cord = route[mem_noc_cid_width_gp +: mem_noc_cord_width_gp];
    want.dst_cid  = route[mem_noc_cid_width_gp-1:0];
    want.src_cord = model_cord;
    want.opcode   = opcode;
    want.addr     = addr;
    want.data     = (opcode == mem_op_store_gp) ? data : '0;
    exp_q.push_back(want);
    cmd_v_i      = 1'b1;
    cmd_opcode_i = opcode;
    cmd_addr_i   = addr;
    cmd_data_i   = data;
    next_cycle();
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
    begin
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic cfg_write(input logic addr, input logic [mem_noc_cord_width_gp-1:0] data);
    cfg_w_v_i  = 1'b1;
    cfg_addr_i = addr;
    cfg_data_i = data;
    next_cycle();
    if (addr == cfg_reg_cord_gp)
      model_cord = data;
    else
      model_dram_en = data[0];
  endtask

  task automatic cfg_read_check(input logic addr,
                                input logic [mem_noc_cord_width_gp-1:0] exp);
    cfg_addr_i = addr;
    next_cycle();
    check_word("cfg_data_o", dword_width_gp'(cfg_data_o), dword_width_gp'(exp));
  endtask

  // Mix of device, DRAM, off-chip and fully random addresses
  task automatic random_addr(output logic [paddr_width_gp-1:0] addr);
    logic [31:0] r;
    logic [31:0] r2;
    r  = $random(seed);
    r2 = $random(seed);
    case (r[1:0])
      2'd0: addr = {16'h0000, 1'b0, r[4:2], r2[19:0]};
      2'd1: addr = {2'b00, r[10:5], 1'b1, r2[30:0]};
      2'd2: addr = {1'b1, r[5], r2, r[11:6]};
      default: addr = {r[7:0], r2};
    endcase
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %s finished with %0d mismatches", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  task automatic test_reset_cfg();
    check_bit("pkt_v_o after reset", pkt_v_o, 1'b0);
    cfg_read_check(cfg_reg_cord_gp, 8'h00);
    cfg_read_check(cfg_reg_dram_en_gp, 8'h00);
    cfg_write(cfg_reg_cord_gp, 8'h5a);
    cfg_write(cfg_reg_dram_en_gp, 8'h01);
    cfg_read_check(cfg_reg_cord_gp, 8'h5a);
    cfg_read_check(cfg_reg_dram_en_gp, 8'h01);
    cfg_write(cfg_reg_dram_en_gp, 8'h00);
    cfg_write(cfg_reg_cord_gp, 8'h31);
    cfg_read_check(cfg_reg_cord_gp, 8'h31);
    finish_test("reset_and_cfg");
  endtask

  task automatic test_device_routes();
    for (int id = 0; id < num_core_lp; id++)
    begin
      send_cmd(mem_op_load_gp, 40'h00_0020_0000 | (40'(id) << 16), '0);
      send_cmd(mem_op_store_gp, 40'h00_0030_0000 | (40'(id) << 2), 64'h1);
      send_cmd(mem_op_load_gp, 40'h00_0030_4000 | (40'(id) << 3), '0);
      send_cmd(mem_op_load_gp, 40'h00_0050_0000 | (40'(id) << 3), '0);
      drain();
    end
    send_cmd(mem_op_load_gp, 40'h00_0010_0040, '0);
    send_cmd(mem_op_load_gp, 40'h00_0030_b000, '0);
    send_cmd(mem_op_store_gp, 40'h00_0040_0080, 64'h55);
    send_cmd(mem_op_load_gp, 40'h00_0060_0100, '0);
    drain();
    finish_test("device_routes");
  endtask

  task automatic test_dram_routes();
    send_cmd(mem_op_load_gp, 40'h00_8000_1000, '0);
    send_cmd(mem_op_load_gp, 40'h01_2345_6780, '0);
    drain();
    cfg_write(cfg_reg_dram_en_gp, 8'h01);
    send_cmd(mem_op_load_gp, 40'h00_8000_1000, '0);
    send_cmd(mem_op_load_gp, 40'h01_2345_6780, '0);
    send_cmd(mem_op_load_gp, 40'h40_0000_1000, '0);
    send_cmd(mem_op_load_gp, 40'hc0_0010_0000, '0);
    send_cmd(mem_op_load_gp, 40'h00_0070_0000, '0);
    send_cmd(mem_op_load_gp, 40'h00_0000_2000, '0);
    drain();
    finish_test("dram_and_offchip");
  endtask

  task automatic test_payload();
    logic [paddr_width_gp-1:0] addr;
    for (int i = 0; i < 16; i++)
    begin
      random_addr(addr);
      send_cmd(i[0], addr, {$random(seed), $random(seed)});
      next_cycle();
    end
    drain();
    finish_test("payload");
  endtask

  task automatic test_stream();
    logic [paddr_width_gp-1:0] addr;
    logic [31:0]               r;
    for (int i = 0; i < 20; i++)
    begin
      random_addr(addr);
      r = $random(seed);
      send_cmd(r[0], addr, {$random(seed), r});
    end
    drain();
    finish_test("back_to_back");
  endtask

  // Every route here depends on the tile's own coordinate
  task automatic send_local_routes();
    send_cmd(mem_op_load_gp, 40'h00_0030_b000, '0);
    send_cmd(mem_op_store_gp, 40'h00_0040_0000, 64'hcafe);
    send_cmd(mem_op_load_gp, 40'h00_0060_0000, '0);
    send_cmd(mem_op_load_gp, 40'h00_9000_0000, '0);
    drain();
  endtask

  task automatic test_cfg_change();
    send_local_routes();
    cfg_write(cfg_reg_cord_gp, 8'h72);
    send_local_routes();
    // Both x and y wrap around at the mesh edge
    cfg_write(cfg_reg_cord_gp, 8'hff);
    send_local_routes();
    // A write beside the command is already seen when that command is routed
    cfg_w_v_i  = 1'b1;
    cfg_addr_i = cfg_reg_cord_gp;
    cfg_data_i = 8'h45;
    model_cord = 8'h45;
    send_cmd(mem_op_load_gp, 40'h00_0040_0000, '0);
    drain();
    finish_test("cfg_change");
  endtask

  initial
  begin
    seed              = 32'hbf9b_2e49;
    tick              = 0;
    cycles            = 0;
    error_count       = 0;
    check_count       = 0;
    test_count        = 0;
    test_start_errors = 0;
    model_cord        = '0;
    model_dram_en     = 1'b0;
    rst_n_i           = 1'b0;
    cfg_w_v_i         = 1'b0;
    cfg_addr_i        = 1'b0;
    cfg_data_i        = '0;
    cmd_v_i           = 1'b0;
    cmd_opcode_i      = 1'b0;
    cmd_addr_i        = '0;
    cmd_data_i        = '0;
    repeat (4) next_cycle();
    rst_n_i = 1'b1;
    test_reset_cfg();
    test_device_routes();
    test_dram_routes();
    test_payload();
    test_stream();
    test_cfg_change();
    $display("tests: %0d, checks: %0d, mismatches: %0d", test_count, check_count,
             error_count);
    if (error_count == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: rtl/mem_noc_tile_out.sv
`timescale 1ns/10ps

module mem_noc_tile_out
  import mem_noc_pkg::*;
#(
  parameter int num_core_p      = 4,
  parameter int mem_noc_x_dim_p = 2
)
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Configuration access
  input  logic                             cfg_w_v_i,
  input  logic                             cfg_addr_i,
  input  logic [mem_noc_cord_width_gp-1:0] cfg_data_i,
  output logic [mem_noc_cord_width_gp-1:0] cfg_data_o,

  // Memory commands from the tile
  input  logic                             cmd_v_i,
  input  logic                             cmd_opcode_i,
  input  logic [paddr_width_gp-1:0]        cmd_addr_i,
  input  logic [dword_width_gp-1:0]        cmd_data_i,

  // Packets toward the mesh router
  output logic                             pkt_v_o,
  output logic [mem_noc_cord_width_gp-1:0] pkt_dst_cord_o,
  output logic [mem_noc_cid_width_gp-1:0]  pkt_dst_cid_o,
  output logic [mem_noc_cord_width_gp-1:0] pkt_src_cord_o,
  output logic                             pkt_opcode_o,
  output logic [paddr_width_gp-1:0]        pkt_addr_o,
  output logic [dword_width_gp-1:0]        pkt_data_o
);

  logic [mem_noc_cord_width_gp-1:0] my_cord;
  logic                             dram_en;

  tile_cfg_regs cfg_regs0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_w_v_i  (cfg_w_v_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .cfg_data_o (cfg_data_o),
    .my_cord_o  (my_cord),
    .dram_en_o  (dram_en)
  );

  mem_cmd_packetizer #(
    .num_core_p      (num_core_p),
    .mem_noc_x_dim_p (mem_noc_x_dim_p)
  ) packetizer0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_v_i        (cmd_v_i),
    .cmd_opcode_i   (cmd_opcode_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .my_cord_i      (my_cord),
    .dram_en_i      (dram_en),
    .pkt_v_o        (pkt_v_o),
    .pkt_dst_cord_o (pkt_dst_cord_o),
    .pkt_dst_cid_o  (pkt_dst_cid_o),
    .pkt_src_cord_o (pkt_src_cord_o),
    .pkt_opcode_o   (pkt_opcode_o),
    .pkt_addr_o     (pkt_addr_o),
    .pkt_data_o     (pkt_data_o)
  );

endmodule

// File: rtl/mem_cmd_packetizer.sv
`timescale 1ns/10ps

module mem_cmd_packetizer
  import mem_noc_pkg::*;
#(
  parameter int num_core_p      = 4,
  parameter int mem_noc_x_dim_p = 2
)
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Incoming memory command
  input  logic                             cmd_v_i,
  input  logic                             cmd_opcode_i,
  input  logic [paddr_width_gp-1:0]        cmd_addr_i,
  input  logic [dword_width_gp-1:0]        cmd_data_i,

  // Tile configuration
  input  logic [mem_noc_cord_width_gp-1:0] my_cord_i,
  input  logic                             dram_en_i,

  // Routed packet
  output logic                             pkt_v_o,
  output logic [mem_noc_cord_width_gp-1:0] pkt_dst_cord_o,
  output logic [mem_noc_cid_width_gp-1:0]  pkt_dst_cid_o,
  output logic [mem_noc_cord_width_gp-1:0] pkt_src_cord_o,
  output logic                             pkt_opcode_o,
  output logic [paddr_width_gp-1:0]        pkt_addr_o,
  output logic [dword_width_gp-1:0]        pkt_data_o
);

  logic                             s1_v_r;
  logic                             s1_opcode_r;
  bp_paddr_u                        s1_addr_r;
  logic [dword_width_gp-1:0]        s1_data_r;

  logic [mem_noc_cord_width_gp-1:0] route_cord;
  logic [mem_noc_cid_width_gp-1:0]  route_cid;

  logic                             s2_v_r;
  logic [mem_noc_cord_width_gp-1:0] s2_dst_cord_r;
  logic [mem_noc_cid_width_gp-1:0]  s2_dst_cid_r;
  logic [mem_noc_cord_width_gp-1:0] s2_src_cord_r;
  logic                             s2_opcode_r;
  logic [paddr_width_gp-1:0]        s2_addr_r;
  logic [dword_width_gp-1:0]        s2_data_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_r <= 1'b0;
      s2_v_r <= 1'b0;
    end
    else
    begin
      s1_v_r <= cmd_v_i;
      s2_v_r <= s1_v_r;
    end
  end

  // Stage 1 holds the command while the address map decodes it
  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      s1_opcode_r <= cmd_opcode_i;
      s1_addr_r   <= cmd_addr_i;
      s1_data_r   <= cmd_data_i;
    end
  end

  mem_addr_map #(
    .num_core_p      (num_core_p),
    .mem_noc_x_dim_p (mem_noc_x_dim_p)
  ) addr_map0 (
    .my_cord_i  (my_cord_i),
    .paddr_i    (s1_addr_r),
    .dram_en_i  (dram_en_i),
    .dst_cord_o (route_cord),
    .dst_cid_o  (route_cid)
  );

  // Stage 2 captures the route together with the coordinate it was made with
  always_ff @(posedge clk_i)
  begin
    if (s1_v_r)
    begin
      s2_dst_cord_r <= route_cord;
      s2_dst_cid_r  <= route_cid;
      s2_src_cord_r <= my_cord_i;
      s2_opcode_r   <= s1_opcode_r;
      s2_addr_r     <= s1_addr_r;
      // Loads carry no payload
      s2_data_r     <= (s1_opcode_r == mem_op_store_gp) ? s1_data_r : '0;
    end
  end

  assign pkt_v_o        = s2_v_r;
  assign pkt_dst_cord_o = s2_dst_cord_r;
  assign pkt_dst_cid_o  = s2_dst_cid_r;
  assign pkt_src_cord_o = s2_src_cord_r;
  assign pkt_opcode_o   = s2_opcode_r;
  assign pkt_addr_o     = s2_addr_r;
  assign pkt_data_o     = s2_data_r;

endmodule

// File: rtl/mem_addr_map.sv
`timescale 1ns/10ps

module mem_addr_map
  import mem_noc_pkg::*;
#(
  parameter int num_core_p      = 4,
  parameter int mem_noc_x_dim_p = 2
)
(
  input  logic [mem_noc_cord_width_gp-1:0] my_cord_i,

  // Address of the command being routed
  input  bp_paddr_u                        paddr_i,
  input  logic                             dram_en_i,

  // Destination router and client
  output logic [mem_noc_cord_width_gp-1:0] dst_cord_o,
  output logic [mem_noc_cid_width_gp-1:0]  dst_cid_o
);

  localparam int core_id_width_lp = (num_core_p > 1) ? $clog2(num_core_p) : 1;

  // Off-chip traffic leaves through the I/O router at the origin
  localparam logic [mem_noc_cord_width_gp-1:0] io_cord_lp = '0;

  // Cores sit in a grid that starts at column 2 and row 1
  function automatic logic [mem_noc_cord_width_gp-1:0] core_id_to_cord
    (input logic [core_id_width_lp-1:0] core_id);
    logic [mem_noc_x_cord_width_gp-1:0] x_cord;
    logic [mem_noc_y_cord_width_gp-1:0] y_cord;
    x_cord = mem_noc_x_cord_width_gp'(int'(core_id) % mem_noc_x_dim_p + 2);
    y_cord = mem_noc_y_cord_width_gp'(int'(core_id) / mem_noc_x_dim_p + 1);
    return {y_cord, x_cord};
  endfunction

  logic [mem_noc_x_cord_width_gp-1:0] my_x_cord;
  logic [mem_noc_y_cord_width_gp-1:0] my_y_cord;
  logic [mem_noc_cord_width_gp-1:0]   coproc_cord;
  logic [mem_noc_cord_width_gp-1:0]   dram_cord;
  logic [mem_noc_cord_width_gp-1:0]   dram_route_cord;
  logic [clint_offset_width_gp-1:0]   clint_offset;
  logic                               in_dev_region;

  assign my_x_cord = my_cord_i[0 +: mem_noc_x_cord_width_gp];
  assign my_y_cord = my_cord_i[mem_noc_x_cord_width_gp +: mem_noc_y_cord_width_gp];

  // The coprocessor is one column east, DRAM one row south
  assign coproc_cord = {my_y_cord, my_x_cord + 1'b1};
  assign dram_cord   = {my_y_cord + 1'b1, my_x_cord};

  // Without local DRAM the request goes to the next chip
  assign dram_route_cord = dram_en_i ? dram_cord : io_cord_lp;

  assign clint_offset  = paddr_i.dev.dev_offset[clint_offset_lsb_gp +: clint_offset_width_gp];
  assign in_dev_region = paddr_i.dram.offset
                         < dram_base_addr_gp[dram_offset_width_gp-1:0];

  always_comb
  begin
    // Unmatched device space falls through to DRAM
    dst_cord_o = dram_route_cord;
    dst_cid_o  = cid_base_gp;

    if (paddr_i.dram.chid != '0)
    begin
      dst_cord_o = io_cord_lp;
      dst_cid_o  = cid_base_gp;
    end
    else if (in_dev_region)
    begin
      case (paddr_i.dev.dev_id)
        dev_host_gp:
        begin
          dst_cord_o = io_cord_lp;
          dst_cid_o  = cid_base_gp;
        end
        dev_cfg_gp:
        begin
          dst_cord_o = core_id_to_cord(
            paddr_i.dev.dev_offset[cfg_core_lsb_gp +: core_id_width_lp]);
          dst_cid_o  = cid_cfg_gp;
        end
        dev_clint_gp:
        begin
          if (clint_offset == clint_ipi_gp)
          begin
            dst_cord_o = core_id_to_cord(
              paddr_i.dev.dev_offset[clint_ipi_core_lsb_gp +: core_id_width_lp]);
            dst_cid_o  = cid_clint_gp;
          end
          else if (clint_offset == clint_mtimecmp_gp)
          begin
            dst_cord_o = core_id_to_cord(
              paddr_i.dev.dev_offset[clint_mtimecmp_core_lsb_gp +: core_id_width_lp]);
            dst_cid_o  = cid_clint_gp;
          end
          else if (clint_offset == clint_mtime_gp)
          begin
            // Only the local mtime register is reachable
            dst_cord_o = my_cord_i;
            dst_cid_o  = cid_clint_gp;
          end
        end
        dev_cce_gp:
        begin
          dst_cord_o = my_cord_i;
          dst_cid_o  = cid_base_gp;
        end
        dev_plic_gp:
        begin
          dst_cord_o = core_id_to_cord(
            paddr_i.dev.dev_offset[plic_core_lsb_gp +: core_id_width_lp]);
          dst_cid_o  = cid_base_gp;
        end
        dev_coproc_gp:
        begin
          dst_cord_o = coproc_cord;
          dst_cid_o  = cid_base_gp;
        end
        default:
        begin
          dst_cord_o = dram_route_cord;
          dst_cid_o  = cid_base_gp;
        end
      endcase
    end
  end

endmodule

// File: rtl/tile_cfg_regs.sv
`timescale 1ns/10ps

module tile_cfg_regs
  import mem_noc_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // Register write port
  input  logic                             cfg_w_v_i,
  input  logic                             cfg_addr_i,
  input  logic [mem_noc_cord_width_gp-1:0] cfg_data_i,

  // Register read-back
  output logic [mem_noc_cord_width_gp-1:0] cfg_data_o,

  // Values seen by the address map
  output logic [mem_noc_cord_width_gp-1:0] my_cord_o,
  output logic                             dram_en_o
);

  logic [mem_noc_cord_width_gp-1:0] my_cord_r;
  logic                             dram_en_r;

  // The tile starts at coordinate 0 with DRAM routing disabled
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      my_cord_r <= '0;
      dram_en_r <= 1'b0;
    end
    else if (cfg_w_v_i)
    begin
      if (cfg_addr_i == cfg_reg_cord_gp)
      begin
        my_cord_r <= cfg_data_i;
      end
      else
      begin
        // Only the lowest data bit is kept for the enable flag
        dram_en_r <= cfg_data_i[0];
      end
    end
  end

  // Read-back is combinational, the enable bit comes back zero-extended
  always_comb
  begin
    if (cfg_addr_i == cfg_reg_dram_en_gp)
    begin
      cfg_data_o = {{(mem_noc_cord_width_gp-1){1'b0}}, dram_en_r};
    end
    else
    begin
      cfg_data_o = my_cord_r;
    end
  end

  assign my_cord_o = my_cord_r;
  assign dram_en_o = dram_en_r;

endmodule

// File: rtl/mem_noc_pkg.sv
package mem_noc_pkg;

  // Physical address and data widths
  localparam int paddr_width_gp = 40;
  localparam int dword_width_gp = 64;

  // Mesh coordinate layout: x in the low bits, y in the high bits
  localparam int mem_noc_x_cord_width_gp = 4;
  localparam int mem_noc_y_cord_width_gp = 4;
  localparam int mem_noc_cord_width_gp   = mem_noc_x_cord_width_gp + mem_noc_y_cord_width_gp;
  localparam int mem_noc_cid_width_gp    = 2;
  localparam int mem_noc_chid_width_gp   = 2;

  // Field widths of the two address views
  localparam int dev_id_width_gp     = 4;
  localparam int dev_offset_width_gp = 20;
  localparam int dev_upper_width_gp  = paddr_width_gp - mem_noc_chid_width_gp
                                       - dev_id_width_gp - dev_offset_width_gp;
  localparam int dram_offset_width_gp = paddr_width_gp - mem_noc_chid_width_gp;

  // Everything on chip zero below this address is a device
  localparam logic [paddr_width_gp-1:0] dram_base_addr_gp = 40'h00_8000_0000;

  // Device ids, taken from address bits 23 to 20
  localparam logic [dev_id_width_gp-1:0] dev_host_gp   = 4'd1;
  localparam logic [dev_id_width_gp-1:0] dev_cfg_gp    = 4'd2;
  localparam logic [dev_id_width_gp-1:0] dev_clint_gp  = 4'd3;
  localparam logic [dev_id_width_gp-1:0] dev_cce_gp    = 4'd4;
  localparam logic [dev_id_width_gp-1:0] dev_plic_gp   = 4'd5;
  localparam logic [dev_id_width_gp-1:0] dev_coproc_gp = 4'd6;

  // CLINT register offsets live in bits 15 to 12 of the device offset
  localparam int clint_offset_lsb_gp   = 12;
  localparam int clint_offset_width_gp = 4;

  localparam logic [clint_offset_width_gp-1:0] clint_ipi_gp      = 4'd0;
  localparam logic [clint_offset_width_gp-1:0] clint_mtimecmp_gp = 4'd4;
  localparam logic [clint_offset_width_gp-1:0] clint_mtime_gp    = 4'd11;

  // Bit positions of the core id inside each device offset
  localparam int clint_ipi_core_lsb_gp      = 2;
  localparam int clint_mtimecmp_core_lsb_gp = 3;
  localparam int cfg_core_lsb_gp            = 16;
  localparam int plic_core_lsb_gp           = 3;

  // Client ids at the destination router
  localparam logic [mem_noc_cid_width_gp-1:0] cid_base_gp  = 2'd0;
  localparam logic [mem_noc_cid_width_gp-1:0] cid_cfg_gp   = 2'd1;
  localparam logic [mem_noc_cid_width_gp-1:0] cid_clint_gp = 2'd2;

  // Memory command opcodes
  localparam logic mem_op_load_gp  = 1'b0;
  localparam logic mem_op_store_gp = 1'b1;

  // Tile configuration register addresses
  localparam logic cfg_reg_cord_gp    = 1'b0;
  localparam logic cfg_reg_dram_en_gp = 1'b1;

  // A physical address is either a device access or a DRAM access
  typedef union packed {
    struct packed {
      logic [mem_noc_chid_width_gp-1:0] chid;
      logic [dev_upper_width_gp-1:0]    upper;
      logic [dev_id_width_gp-1:0]       dev_id;
      logic [dev_offset_width_gp-1:0]   dev_offset;
    } dev;
    struct packed {
      logic [mem_noc_chid_width_gp-1:0] chid;
      logic [dram_offset_width_gp-1:0]  offset;
    } dram;
  } bp_paddr_u;

endpackage
